/* testbench/led_cases.txt */
# Columns: cycles to run, reset before the run (1 = yes), then the expected
# high cycles of led1_grn, led1_red, led2_grn, led2_red over the run
# Flash sequence plus the first PWM cycle
962 1 1 448 0 449
# Rest of the PWM period, then two full periods
64 0 60 0 0 31
256 0 230 30 146 252
256 0 201 1 182 224
# Reset in the PWM phase, run partway into the flash
200 1 0 71 0 71
# Reset in the flash phase, full sequence again
962 1 1 448 0 449
64 0 60 0 0 31
256 0 230 30 146 252

/* filelist.f */
+incdir+rtl
rtl/led_pkg.sv
rtl/led_tick_gen.sv
rtl/led_breath_pwm.sv
rtl/led_output_mux.sv
rtl/led_ctrl.sv
testbench/led_ctrl_assert.sv
testbench/led_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LED controller testbench with Verilator
# The result comes from the simulation log

cd "$(dirname "$0")" || exit 1

top=led_ctrl_tb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module "$top" \
    --Mdir "$build_dir" \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
fi

if grep -qx "TESTS PASSED" "$log_file"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $log_file"
    exit 1
fi

/* testbench/led_ctrl_tb.sv */
`include "led_macros.svh"

module led_ctrl_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_CASES    = 32;
    // Slack for the first reset and the final cycles
    localparam int MARGIN       = 100;

    // Spans used by the cycle model
    localparam int PHASE_SPAN = 1 << `LED_PHASE_BITS;
    localparam int HALF_SPAN  = PHASE_SPAN / 2;
    localparam int PWM_SPAN   = 1 << `LED_PWM_BITS;
    localparam int LEVEL_DIV  = 1 << (`LED_PHASE_BITS - 1 - `LED_PWM_BITS);

    logic sysclk;
    logic reset;
    logic led1_grn;
    logic led1_red;
    logic led2_grn;
    logic led2_red;

    // Replay table
    int case_len   [MAX_CASES];
    int case_reset [MAX_CASES];
    int case_high  [MAX_CASES][`LED_CHANNELS];
    int case_count;

    // Cycles since the last reset release
    int cycle_index;
    int watchdog_cycles;

    led_ctrl u_led_ctrl (
        .sysclk   (sysclk),
        .reset    (reset),
        .led1_grn (led1_grn),
        .led1_red (led1_red),
        .led2_grn (led2_grn),
        .led2_red (led2_red)
    );

    always #(CLK_PERIOD / 2) sysclk = ~sysclk;

    //////////////////////////////////////////////////
    // Cycle model
    //////////////////////////////////////////////////

    // Start phases, green then red per LED
    function automatic int seed_of(int ch);
        case (ch)
            0: return 250;
            1: return 700;
            2: return 0;
            default: return 200;
        endcase
    endfunction

    function automatic string out_name(int ch);
        case (ch)
            0: return "led1_grn";
            1: return "led1_red";
            2: return "led2_grn";
            default: return "led2_red";
        endcase
    endfunction

    // Triangle over the ramp, then drop to the duty width
    function automatic int fold_level(int phase);
        int low;
        low = phase % HALF_SPAN;
        // Upper half runs back down
        if (phase >= HALF_SPAN) begin
            low = HALF_SPAN - 1 - low;
        end
        return low / LEVEL_DIV;
    endfunction

    // Channel register in cycle c, compare made one cycle earlier
    function automatic logic channel_bit(int ch, int c);
        int prev;
        int phase;
        if (c == 0) begin
            return 1'b0;
        end
        prev = c - 1;
        // One step strobe per divider period, first at DIV-1
        phase = (seed_of(ch) + prev / `LED_STEP_DIV) % PHASE_SPAN;
        return (prev % PWM_SPAN) < fold_level(phase);
    endfunction

    // Top output in cycle n after release
    function automatic logic expected_out(int ch, int n);
        int c;
        int ticks;
        if (n == 0) begin
            return 1'b0;
        end
        c = n - 1;
        // Flash ticks seen before cycle c
        ticks = c / `LED_FLASH_DIV;
        if (ticks < `LED_FLASH_TICKS) begin
            if (ch % 2 == 0) begin
                return 1'b0;
            end
            return (ticks % 2) == 1;
        end
        return channel_bit(ch, c);
    endfunction

    //////////////////////////////////////////////////
    // Checks and failure exit
    //////////////////////////////////////////////////

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s at cycle %0d expected 0x%0h actual 0x%0h",
                name, cycle_index, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // Case file
    //////////////////////////////////////////////////

    task automatic load_cases();
        int fd;
        int fields;
        int total;
        int len;
        int rst;
        int h0;
        int h1;
        int h2;
        int h3;
        string line;
        fd = $fopen("testbench/led_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the case file testbench/led_cases.txt");
        end
        total = MARGIN;
        while ($feof(fd) == 0) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%d %d %d %d %d %d", len, rst, h0, h1, h2, h3);
                // Comment lines give no fields
                if (fields == 6) begin
                    if (case_count == MAX_CASES) begin
                        abort_run("The case file holds more cases than the table");
                    end
                    case_len[case_count]      = len;
                    case_reset[case_count]    = rst;
                    case_high[case_count][0]  = h0;
                    case_high[case_count][1]  = h1;
                    case_high[case_count][2]  = h2;
                    case_high[case_count][3]  = h3;
                    case_count++;
                    total += len + RESET_CYCLES;
                end else if (fields > 0) begin
                    abort_run("A line of the case file has too few fields");
                end
            end
        end
        $fclose(fd);
        if (case_count == 0) begin
            abort_run("The case file holds no cases");
        end
        watchdog_cycles = total;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic apply_reset();
        @(posedge sysclk);
        #1 reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        #1 reset = 1'b1;
        cycle_index = 0;
    endtask

    // Every cycle against the model, then the window counts
    task automatic run_case(int idx);
        int high_count [`LED_CHANNELS];
        logic [`LED_CHANNELS-1:0] seen;
        for (int ch = 0; ch < `LED_CHANNELS; ch++) begin
            high_count[ch] = 0;
        end
        repeat (case_len[idx]) begin
            @(negedge sysclk);
            seen = {led2_red, led2_grn, led1_red, led1_grn};
            for (int ch = 0; ch < `LED_CHANNELS; ch++) begin
                check_value(out_name(ch), 32'(expected_out(ch, cycle_index)), 32'(seen[ch]));
                if (seen[ch]) begin
                    high_count[ch]++;
                end
            end
            cycle_index++;
        end
        for (int ch = 0; ch < `LED_CHANNELS; ch++) begin
            check_value({"high count of ", out_name(ch)}, case_high[idx][ch], high_count[ch]);
        end
    endtask

    initial begin
        sysclk          = 1'b0;
        reset           = 1'b0;
        cycle_index     = 0;
        watchdog_cycles = 0;
        case_count      = 0;
        load_cases();
        for (int i = 0; i < case_count; i++) begin
            // First case always starts from reset
            if (i == 0 || case_reset[i] != 0) begin
                apply_reset();
            end
            run_case(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

    // Watchdog, armed once the case lengths are known
    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        abort_run($sformatf("Run timed out after %0d cycles", watchdog_cycles));
    end

endmodule

/* testbench/led_ctrl_assert.sv */
`include "led_macros.svh"

module led_ctrl_assert (
    input logic                                sysclk,
    input logic                                reset,
    input led_pkg::led_tick_t                  tick,
    input led_pkg::led_pair_t [`LED_COUNT-1:0] led,
    input logic                                flash_mode,
    input logic                                flash_red
);

    // Green bits of all LEDs
    logic [`LED_COUNT-1:0] greens;

    always_comb begin
        for (int i = 0; i < `LED_COUNT; i++) begin
            greens[i] = led[i].grn;
        end
    end

    //////////////////////////////////////////////////
    // Flash sequence rules
    //////////////////////////////////////////////////

    // Outputs lag the mode by one register
    green_dark: assert property (
        @(posedge sysclk) disable iff (!reset)
        $past(flash_mode) |-> (greens == '0)
    ) else $error("Green element lit during the flash sequence");

    // Blink pattern moves only on a tick
    red_on_tick: assert property (
        @(posedge sysclk) disable iff (!reset)
        (flash_red != $past(flash_red)) |-> $past(tick.flash)
    ) else $error("Flash red changed without a flash tick");

    // Only reset starts the sequence again
    mode_no_rise: assert property (
        @(posedge sysclk) disable iff (!reset)
        !$rose(flash_mode)
    ) else $error("Flash mode rose outside reset");

    mode_ends_on_tick: assert property (
        @(posedge sysclk) disable iff (!reset)
        $fell(flash_mode) |-> $past(tick.flash)
    ) else $error("Flash mode ended without a flash tick");

endmodule

// Attach to every output mux
bind led_output_mux led_ctrl_assert u_ctrl_assert (
    .sysclk     (sysclk),
    .reset      (reset),
    .tick       (tick),
    .led        (led),
    .flash_mode (flash_mode),
    .flash_red  (flash_red)
);

/* rtl/led_ctrl.sv */
`include "led_macros.svh"

module led_ctrl (
    input  logic sysclk,
    input  logic reset,
    output logic led1_grn,
    output logic led1_red,
    output logic led2_grn,
    output logic led2_red
);

    led_pkg::led_tick_t                      tick;
    logic [`LED_CHANNELS-1:0]                chan_pwm;
    led_pkg::led_pair_t [`LED_COUNT-1:0]     pwm_pair;
    led_pkg::led_pair_t [`LED_COUNT-1:0]     led;

    // Shared rates for all channels and the sequencer
    led_tick_gen u_tick_gen (
        .sysclk (sysclk),
        .reset  (reset),
        .tick   (tick)
    );

    //////////////////////////////////////////////////
    // Breathing channels
    //////////////////////////////////////////////////

    for (genvar ch = 0; ch < `LED_CHANNELS; ch++) begin : g_chan
        led_breath_pwm #(
            .channel (ch)
        ) u_breath (
            .sysclk (sysclk),
            .reset  (reset),
            .tick   (tick),
            .pwm    (chan_pwm[ch])
        );
    end

    // Even channel is green, odd is red
    for (genvar k = 0; k < `LED_COUNT; k++) begin : g_pair
        assign pwm_pair[k].grn = chan_pwm[2*k];
        assign pwm_pair[k].red = chan_pwm[2*k+1];
    end

    // Flash override and output registers
    led_output_mux u_output_mux (
        .sysclk (sysclk),
        .reset  (reset),
        .tick   (tick),
        .pwm    (pwm_pair),
        .led    (led)
    );

    // Pins
    assign led1_grn = led[0].grn;
    assign led1_red = led[0].red;
    assign led2_grn = led[1].grn;
    assign led2_red = led[1].red;

endmodule

/* rtl/led_output_mux.sv */
`include "led_macros.svh"

module led_output_mux (
    input  logic                                     sysclk,
    input  logic                                     reset,
    input  led_pkg::led_tick_t                       tick,
    input  led_pkg::led_pair_t [`LED_COUNT-1:0]      pwm,
    output led_pkg::led_pair_t [`LED_COUNT-1:0]      led
);

    // Tick counter wide enough to hold the limit
    localparam int CNT_BITS = $clog2(`LED_FLASH_TICKS + 1);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`LED_FLASH_TICKS - 1);

    logic                flash_mode;
    logic                flash_red;
    logic [CNT_BITS-1:0] flash_cnt;

    //////////////////////////////////////////////////
    // Post-reset flash sequencer
    //////////////////////////////////////////////////

    // Starts in flash mode after every reset
    // Each flash tick toggles the red pattern
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            flash_mode <= 1'b1;
            flash_red  <= 1'b0;
            flash_cnt  <= '0;
        end else if (flash_mode && tick.flash) begin
            flash_red <= ~flash_red;
            flash_cnt <= flash_cnt + 1'b1;
            // Last tick hands the outputs to the channels
            if (flash_cnt == CNT_LAST) begin
                flash_mode <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Output selection
    //////////////////////////////////////////////////

    // Registered choice per element
    // Greens dark and reds blinking during flash
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            led <= '0;
        end else begin
            for (int i = 0; i < `LED_COUNT; i++) begin
                if (flash_mode) begin
                    led[i].grn <= 1'b0;
                    led[i].red <= flash_red;
                end else begin
                    // Straight from the channel compare
                    led[i].grn <= pwm[i].grn;
                    led[i].red <= pwm[i].red;
                end
            end
        end
    end

endmodule

/* rtl/led_breath_pwm.sv */
`include "led_macros.svh"

module led_breath_pwm #(
    // Index into the start phase table
    parameter int channel = 0
) (
    input  logic                sysclk,
    input  logic                reset,
    input  led_pkg::led_tick_t  tick,
    output logic                pwm
);

    // Ramp half width, one bit less than the phase
    localparam int HALF_BITS = `LED_PHASE_BITS - 1;

    // Seed for this channel
    localparam logic [`LED_PHASE_BITS-1:0] SEED = led_pkg::START_PHASE[channel];

    logic [`LED_PHASE_BITS-1:0] phase;
    logic [HALF_BITS-1:0]       fold;
    logic [`LED_PWM_BITS-1:0]   level;

    //////////////////////////////////////////////////
    // Phase ramp
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            phase <= SEED;
        end else if (tick.step) begin
            // Wraps from all ones back to zero
            phase <= phase + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Triangular fold
    //////////////////////////////////////////////////

    // Rising half passes through
    // Falling half mirrors the low bits
    always_comb begin
        if (phase[`LED_PHASE_BITS-1]) begin
            fold = ~phase[HALF_BITS-1:0];
        end else begin
            fold = phase[HALF_BITS-1:0];
        end
    end

    // Upper bits of the fold set brightness
    assign level = fold[HALF_BITS-1 -: `LED_PWM_BITS];

    //////////////////////////////////////////////////
    // Duty compare
    //////////////////////////////////////////////////

    // High while the shared count is below the level
    // Level 0 keeps the element dark
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (tick.pwm_count < level);
        end
    end

endmodule

/* rtl/led_tick_gen.sv */
`include "led_macros.svh"

module led_tick_gen (
    input  logic                sysclk,
    input  logic                reset,
    output led_pkg::led_tick_t  tick
);

    // Divider widths and terminal counts
    localparam int STEP_BITS  = $clog2(`LED_STEP_DIV);
    localparam int FLASH_BITS = $clog2(`LED_FLASH_DIV);
    localparam logic [STEP_BITS-1:0]  STEP_LAST  = STEP_BITS'(`LED_STEP_DIV - 1);
    localparam logic [FLASH_BITS-1:0] FLASH_LAST = FLASH_BITS'(`LED_FLASH_DIV - 1);

    logic [`LED_PWM_BITS-1:0] pwm_count;
    logic [STEP_BITS-1:0]     step_cnt;
    logic [FLASH_BITS-1:0]    flash_cnt;

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            pwm_count <= '0;
            step_cnt  <= '0;
            flash_cnt <= '0;
        end else begin
            // Duty counter wraps on its own width
            pwm_count <= pwm_count + 1'b1;

            // Modulo dividers, explicit wrap
            if (step_cnt == STEP_LAST) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end

            if (flash_cnt == FLASH_LAST) begin
                flash_cnt <= '0;
            end else begin
                flash_cnt <= flash_cnt + 1'b1;
            end
        end
    end

    // Strobes decode the last count of each divider
    // First pulse lands DIV-1 cycles after reset release
    always_comb begin
        tick.pwm_count = pwm_count;
        tick.step      = (step_cnt == STEP_LAST);
        tick.flash     = (flash_cnt == FLASH_LAST);
    end

endmodule

/* rtl/led_pkg.sv */
`include "led_macros.svh"

package led_pkg;

    //////////////////////////////////////////////////
    // Timing strobes shared by every block
    //////////////////////////////////////////////////

    typedef struct packed {
        // Free-running duty counter
        logic [`LED_PWM_BITS-1:0] pwm_count;
        // Phase advance, one cycle wide
        logic                     step;
        // Flash sequencer tick, one cycle wide
        logic                     flash;
    } led_tick_t;

    //////////////////////////////////////////////////
    // One physical LED
    //////////////////////////////////////////////////

    typedef struct packed {
        logic grn;
        logic red;
    } led_pair_t;

    // Start phase per channel
    // Channel 2k is the green of LED k, 2k+1 its red
    // Index 0 sits in the low bits
    localparam logic [`LED_CHANNELS-1:0][`LED_PHASE_BITS-1:0] START_PHASE = {
        `LED_PHASE_BITS'(200),
        `LED_PHASE_BITS'(0),
        `LED_PHASE_BITS'(700),
        `LED_PHASE_BITS'(250)
    };

endpackage

/* rtl/led_macros.svh */
`ifndef LED_MACROS_SVH
`define LED_MACROS_SVH

//////////////////////////////////////////////////
// Indicator geometry
//////////////////////////////////////////////////

// Physical LEDs, each with a green and a red element
`define LED_COUNT 2
// One PWM channel per element
`define LED_CHANNELS 4

// Phase ramp and brightness widths
`define LED_PHASE_BITS 10
`define LED_PWM_BITS 8

//////////////////////////////////////////////////
// Rates, in sysclk cycles
//////////////////////////////////////////////////

// Cycles between phase steps, short for simulation
`define LED_STEP_DIV 4
// Cycles between flash ticks
`define LED_FLASH_DIV 64
// Red blink length after reset, in flash ticks
`define LED_FLASH_TICKS 15

`endif
